// File: opl_reg_file.f
verilog/opl_reg_pkg.sv
verilog/opl_param_pkg.sv
verilog/reg_write_decode.sv
verilog/channel_reg_slot.sv
verilog/chan_param_readout.sv
verilog/opl_reg_file.sv
sim/tb_opl_reg_file.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_opl_reg_file
FILELIST  := opl_reg_file.f
OBJ_DIR   := obj_dir
SIM_EXE   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$($(SIM_EXE))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_opl_reg_file.sv
//--------------------
// expects the 18-channel build; outputs are compared every cycle
// with a byte mirror of the register map copied on each sample pulse
//--------------------
`timescale 1ns/1ps
`default_nettype none

module tb_opl_reg_file
    import opl_reg_pkg::*;
    import opl_param_pkg::*;
();

    localparam int NUM_CHANS       = 2 * CHANS_PER_BANK;
    localparam int WATCHDOG_CYCLES = 20000;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          wr_en;
    reg_addr_t     wr_addr;
    reg_byte_t     wr_data;
    logic          sample_clk_en;
    chan_idx_t     ch_sel;
    chan_param_t   chan_param;
    global_param_t global_param;

    reg_byte_t     reg_map [512];    // every byte the host wrote
    reg_byte_t     live_map [512];   // reg_map as of the last sample pulse
    chan_param_t   exp_chan;
    global_param_t exp_glb;
    logic [31:0]   rng;
    int            chan_errors = 0;
    int            glb_errors  = 0;
    int            tests       = 0;
    int            test_base   = 0;

    always #20 clk = ~clk;

    opl_reg_file #(
        .NUM_BANKS (2)
    ) opl_reg_file_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .sample_clk_en (sample_clk_en),
        .ch_sel        (ch_sel),
        .chan_param    (chan_param),
        .global_param  (global_param)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // flags, level, attack/decay and sustain/release bytes line up with the struct
    function automatic op_param_t expect_op(int a);
        reg_byte_t w;
        w = live_map[reg_addr_t'(a + 'hE0)];
        return {live_map[reg_addr_t'(a + 'h20)], live_map[reg_addr_t'(a + 'h40)],
                live_map[reg_addr_t'(a + 'h60)], live_map[reg_addr_t'(a + 'h80)], w[2:0]};
    endfunction

    function automatic chan_param_t expect_chan(int c);
        chan_param_t ch;
        int          base;
        int          ci;
        int          slot;
        reg_byte_t   kb;
        reg_byte_t   fbk;
        ch = '0;
        if (c < NUM_CHANS) begin
            base = (c / CHANS_PER_BANK) * BANK_STRIDE;
            ci   = c % CHANS_PER_BANK;
            slot = (ci / 3) * 8 + ci % 3;   // op2 sits three slots higher
            kb   = live_map[reg_addr_t'(base + 'hB0 + ci)];
            fbk  = live_map[reg_addr_t'(base + 'hC0 + ci)];
            ch.op1   = expect_op(base + slot);
            ch.op2   = expect_op(base + slot + 3);
            ch.fnum  = {kb[1:0], live_map[reg_addr_t'(base + 'hA0 + ci)]};
            ch.block = kb[4:2];
            ch.kon   = kb[5];
            {ch.chd, ch.chc, ch.chb, ch.cha, ch.fb, ch.cnt} = fbk;
        end
        return ch;
    endfunction

    function automatic global_param_t expect_glb();
        global_param_t g;
        reg_byte_t     tc;
        tc = live_map[reg_addr_t'('h004)];
        g  = '0;
        g.timer1                = live_map[reg_addr_t'('h002)];
        g.timer2                = live_map[reg_addr_t'('h003)];
        {g.irq_rst, g.mt1, g.mt2} = tc[7:5];
        {g.st2, g.st1}          = tc[1:0];
        g.nts                   = live_map[reg_addr_t'('h008)][6];
        {g.dam, g.dvb, g.ryt, g.bd, g.sd, g.tom, g.tc, g.hh} = live_map[reg_addr_t'('h0BD)];
        g.connection_sel        = live_map[reg_addr_t'('h104)][5:0];
        g.is_new                = live_map[reg_addr_t'('h105)][0];
        return g;
    endfunction

    // expected outputs follow the same two-stage path as the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            live_map <= '{default: '0};
            exp_chan <= '0;
            exp_glb  <= '0;
        end else begin
            if (sample_clk_en) begin
                live_map <= reg_map;
            end
            exp_chan <= expect_chan(int'(ch_sel));
            exp_glb  <= expect_glb();
        end
    end

    chk_chan: assert property (@(posedge clk) disable iff (!rst_n) chan_param == exp_chan)
        else begin
            $display("mismatch chan_param at %0t got %h exp %h", $time,
                     $sampled(chan_param), $sampled(exp_chan));
            chan_errors++;
        end

    chk_glb: assert property (@(posedge clk) disable iff (!rst_n) global_param == exp_glb)
        else begin
            $display("mismatch global_param at %0t got %h exp %h", $time,
                     $sampled(global_param), $sampled(exp_glb));
            glb_errors++;
        end

    task write_rand(input int addr);
        rng = xorshift32(rng);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= reg_addr_t'(addr);
        wr_data <= rng[7:0];
        reg_map[reg_addr_t'(addr)] <= rng[7:0];
    endtask

    task idle(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_en         <= 1'b0;
            sample_clk_en <= 1'b0;
        end
    endtask

    // slots up to last_slot in the five operator groups
    task fill_ops(input int bank, input int last_slot);
        for (int g = 'h20; g <= 'hE0; g += 'h20) begin
            if (g < 'hA0 || g == 'hE0) begin
                for (int s = 0; s <= last_slot; s++) begin
                    write_rand(bank + g + s);
                end
            end
        end
    endtask

    task fill_chans(input int bank, input int count);
        for (int g = 'hA0; g <= 'hC0; g += 'h10) begin
            for (int i = 0; i < count; i++) begin
                write_rand(bank + g + i);
            end
        end
    endtask

    // one-cycle strobe, dropped again on the next edge
    task pulse_sample();
        @(posedge clk);
        wr_en         <= 1'b0;
        sample_clk_en <= 1'b1;
        idle(2);
    endtask

    task sweep(input int first, input int last);
        for (int s = first; s <= last; s++) begin
            @(posedge clk);
            ch_sel <= chan_idx_t'(s);
        end
        idle(3);   // let the last selection reach the checks
    endtask

    task finish_test(input string name);
        int now_err;
        now_err = chan_errors + glb_errors;
        tests++;
        $display("test %0d %s: %0d errors", tests, name, now_err - test_base);
        test_base = now_err;
    endtask

    initial begin
        int errs;
        rst_n         <= 1'b0;
        wr_en         <= 1'b0;
        wr_addr       <= '0;
        wr_data       <= '0;
        sample_clk_en <= 1'b0;
        ch_sel        <= '0;
        rng = 32'h105f345f;
        for (int a = 0; a < 512; a++) begin
            reg_map[reg_addr_t'(a)] <= '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);

        sweep(0, 31);
        pulse_sample();
        sweep(0, 19);
        finish_test("reset");

        fill_ops(0, 31);   // unmapped slots too
        idle(3);
        pulse_sample();
        sweep(0, 17);
        finish_test("operator mapping");

        write_rand('h20);
        write_rand('hA4);
        write_rand('hB4);
        write_rand('hC8);
        idle(3);
        sweep(0, 8);       // live copy still holds the old values
        pulse_sample();
        sweep(0, 8);
        finish_test("shadow isolation");

        fill_chans(0, 16);
        idle(3);
        pulse_sample();
        sweep(0, 8);
        finish_test("channel registers");

        fill_ops(BANK_STRIDE, 21);
        fill_chans(BANK_STRIDE, 9);
        write_rand('h002);
        write_rand('h003);
        write_rand('h004);
        write_rand('h008);
        write_rand('h0BD);
        write_rand('h104);
        write_rand('h105);
        idle(3);
        pulse_sample();
        sweep(9, 17);
        finish_test("bank 2 and globals");

        repeat (200) begin
            rng = xorshift32(rng);
            write_rand(int'(rng[8:0]));
        end
        idle(3);
        pulse_sample();
        sweep(0, 19);
        sweep(31, 31);
        finish_test("random writes");

        errs = chan_errors + glb_errors;
        $display("tests %0d, errors %0d", tests, errs);
        if (errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/opl_reg_file.sv
//--------------------
// NUM_BANKS 1 gives 9 channels, 2 gives 18
//--------------------
`timescale 1ns/1ps
`default_nettype none

module opl_reg_file
    import opl_reg_pkg::*;
    import opl_param_pkg::*;
#(
    parameter int NUM_BANKS = 2
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                wr_en,
    input  wire reg_addr_t     wr_addr,
    input  wire reg_byte_t     wr_data,
    input  wire                sample_clk_en,
    input  wire chan_idx_t     ch_sel,
    output chan_param_t        chan_param,
    output global_param_t      global_param
);

    localparam int NUM_CHANS = NUM_BANKS * CHANS_PER_BANK;

    logic [NUM_CHANS-1:0] chan_wr_en;
    reg_write_t           chan_wr;
    chan_param_t          chans [NUM_CHANS];  // live settings per channel

    reg_write_decode #(
        .NUM_BANKS (NUM_BANKS)
    ) reg_write_decode_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .sample_clk_en (sample_clk_en),
        .chan_wr_en    (chan_wr_en),
        .chan_wr       (chan_wr),
        .global_param  (global_param)
    );

    for (genvar c = 0; c < NUM_CHANS; c++) begin : g_chan
        channel_reg_slot channel_reg_slot_inst (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr_en         (chan_wr_en[c]),
            .wr            (chan_wr),
            .sample_clk_en (sample_clk_en),
            .live          (chans[c])
        );
    end

    chan_param_readout #(
        .NUM_BANKS (NUM_BANKS)
    ) chan_param_readout_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .chans      (chans),
        .ch_sel     (ch_sel),
        .chan_param (chan_param)
    );

endmodule

`default_nettype wire

// File: verilog/chan_param_readout.sv
//--------------------
// out-of-range ch_sel reads as all zeros
//--------------------
`timescale 1ns/1ps
`default_nettype none

module chan_param_readout
    import opl_reg_pkg::*;
    import opl_param_pkg::*;
#(
    parameter int NUM_BANKS = 2
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire chan_param_t   chans [NUM_BANKS*CHANS_PER_BANK],
    input  wire chan_idx_t     ch_sel,
    output chan_param_t        chan_param
);

    localparam int NUM_CHANS = NUM_BANKS * CHANS_PER_BANK;

    logic sel_ok;

    assign sel_ok = ch_sel < chan_idx_t'(NUM_CHANS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan_param <= '0;
        end else if (sel_ok) begin
            chan_param <= chans[ch_sel];
        end else begin
            chan_param <= '0;  // no such channel
        end
    end

    a_oor_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !sel_ok |=> (chan_param == '0));

endmodule

`default_nettype wire

// File: verilog/channel_reg_slot.sv
//--------------------
// live copy only moves on sample_clk_en, so the engine never sees half an update
//--------------------
`timescale 1ns/1ps
`default_nettype none

module channel_reg_slot
    import opl_reg_pkg::*;
    import opl_param_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              wr_en,
    input  wire reg_write_t  wr,
    input  wire              sample_clk_en,
    output chan_param_t      live
);

    chan_param_t shadow;
    op_param_t   op_next;

    // merge one register byte into an operator
    function automatic op_param_t update_op(op_param_t cur, field_kind_e kind, reg_byte_t d);
        op_param_t op;
        op = cur;
        case (kind)
            op_flags: begin
                op.am   = d[7];
                op.vib  = d[6];
                op.egt  = d[5];
                op.ksr  = d[4];
                op.mult = d[3:0];
            end
            op_level: begin
                op.ksl = d[7:6];
                op.tl  = d[5:0];
            end
            op_attack_decay: begin
                op.ar = d[7:4];
                op.dr = d[3:0];
            end
            op_sustain_release: begin
                op.sl = d[7:4];
                op.rr = d[3:0];
            end
            op_wave: op.ws = d[2:0];
            default: ;
        endcase
        return op;
    endfunction

    assign op_next = update_op(wr.op_sel ? shadow.op2 : shadow.op1, wr.kind, wr.data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow <= '0;
            live   <= '0;
        end else begin
            if (wr_en) begin
                case (wr.kind)
                    op_flags, op_level, op_attack_decay, op_sustain_release, op_wave: begin
                        if (wr.op_sel) begin
                            shadow.op2 <= op_next;
                        end else begin
                            shadow.op1 <= op_next;
                        end
                    end
                    ch_fnum_lo: shadow.fnum[7:0] <= wr.data;
                    ch_key_block: begin
                        shadow.kon       <= wr.data[5];
                        shadow.block     <= wr.data[4:2];
                        shadow.fnum[9:8] <= wr.data[1:0];  // fnum high bits
                    end
                    ch_feedback: begin
                        shadow.chd <= wr.data[7];
                        shadow.chc <= wr.data[6];
                        shadow.chb <= wr.data[5];
                        shadow.cha <= wr.data[4];
                        shadow.fb  <= wr.data[3:1];
                        shadow.cnt <= wr.data[0];
                    end
                    default: ;
                endcase
            end
            // a write landing on this same edge waits for the next pulse
            if (sample_clk_en) begin
                live <= shadow;
            end
        end
    end

    // the decoder only forwards writes it classified
    a_known_kind: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr.kind inside {op_flags, op_level, op_attack_decay,
                                   op_sustain_release, op_wave, ch_fnum_lo,
                                   ch_key_block, ch_feedback}));

endmodule

`default_nettype wire

// File: verilog/reg_write_decode.sv
//--------------------
// one write per cycle, no back-pressure; unmapped addresses dropped
// NUM_BANKS 1 drops every write with address bit 8 set
//--------------------
`timescale 1ns/1ps
`default_nettype none

module reg_write_decode
    import opl_reg_pkg::*;
    import opl_param_pkg::*;
#(
    parameter int NUM_BANKS = 2
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   wr_en,
    input  wire reg_addr_t                        wr_addr,
    input  wire reg_byte_t                        wr_data,
    input  wire                                   sample_clk_en,
    output logic [NUM_BANKS*CHANS_PER_BANK-1:0]   chan_wr_en,
    output reg_write_t                            chan_wr,
    output global_param_t                         global_param
);

    localparam int NUM_CHANS = NUM_BANKS * CHANS_PER_BANK;

    logic          bank_sel;
    logic          bank_ok;
    reg_byte_t     offs;
    logic [4:0]    slot;
    logic          is_op;
    logic          is_ch;
    logic          slot_ok;
    logic          chan_ok;
    field_kind_e   kind;
    logic [3:0]    chan_in_bank;
    chan_idx_t     chan;
    logic          chan_hit;
    global_param_t glb_shadow;
    global_param_t glb_live;

    assign bank_sel = wr_addr[8];
    assign bank_ok  = !bank_sel || (NUM_BANKS > 1);
    assign offs     = wr_addr[7:0];
    assign slot     = offs[4:0];

    // group classification, the two masks never select the same base
    always_comb begin
        is_op = 1'b0;
        is_ch = 1'b0;
        kind  = op_flags;
        case (offs & OP_GROUP_MASK)
            OP_FLAGS_BASE, OP_LEVEL_BASE, OP_ATTACK_DECAY_BASE,
            OP_SUST_REL_BASE, OP_WAVE_BASE: begin
                is_op = 1'b1;
                kind  = field_kind_e'(offs & OP_GROUP_MASK);
            end
            default: ;
        endcase
        case (offs & CH_GROUP_MASK)
            CH_FNUM_LO_BASE, CH_KEY_BLOCK_BASE, CH_FEEDBACK_BASE: begin
                is_ch = 1'b1;
                kind  = field_kind_e'(offs & CH_GROUP_MASK);
            end
            default: ;
        endcase
    end

    // slots come in rows of 6 at 0, 8 and 16
    assign slot_ok = (slot[2:0] < 3'd6) && (slot[4:3] != 2'b11);
    assign chan_ok = offs[3:0] < 4'(CHANS_PER_BANK);

    always_comb begin
        if (is_op) begin
            chan_in_bank = 4'(slot[4:3]) * 4'd3 + 4'(slot[2:0] % 3'd3);
        end else begin
            chan_in_bank = offs[3:0];
        end
    end

    assign chan     = (bank_sel ? 5'(CHANS_PER_BANK) : 5'd0) + 5'(chan_in_bank);
    assign chan_hit = wr_en && bank_ok && ((is_op && slot_ok) || (is_ch && chan_ok));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan_wr_en <= '0;
        end else begin
            chan_wr_en <= '0;
            if (chan_hit) begin
                chan_wr_en[chan] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chan_hit) begin
            chan_wr.kind   <= kind;
            chan_wr.op_sel <= is_op && (slot[2:0] >= 3'd3);  // second row half is op2
            chan_wr.data   <= wr_data;
        end
    end

    // globals, shadow then live then output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            glb_shadow   <= '0;
            glb_live     <= '0;
            global_param <= '0;
        end else begin
            if (wr_en && bank_ok) begin
                case (wr_addr)
                    TIMER1_ADDR: glb_shadow.timer1 <= wr_data;
                    TIMER2_ADDR: glb_shadow.timer2 <= wr_data;
                    TIMER_CTRL: begin
                        glb_shadow.irq_rst <= wr_data[7];
                        glb_shadow.mt1     <= wr_data[6];
                        glb_shadow.mt2     <= wr_data[5];
                        glb_shadow.st2     <= wr_data[1];
                        glb_shadow.st1     <= wr_data[0];
                    end
                    NTS_ADDR: glb_shadow.nts <= wr_data[6];
                    RHYTHM_ADDR: begin
                        glb_shadow.dam <= wr_data[7];
                        glb_shadow.dvb <= wr_data[6];
                        glb_shadow.ryt <= wr_data[5];
                        glb_shadow.bd  <= wr_data[4];
                        glb_shadow.sd  <= wr_data[3];
                        glb_shadow.tom <= wr_data[2];
                        glb_shadow.tc  <= wr_data[1];
                        glb_shadow.hh  <= wr_data[0];
                    end
                    CONN_SEL_ADDR: glb_shadow.connection_sel <= wr_data[CONN_SEL_WIDTH-1:0];
                    NEW_ADDR: glb_shadow.is_new <= wr_data[0];
                    default: ;
                endcase
            end
            if (sample_clk_en) begin
                glb_live <= glb_shadow;
            end
            global_param <= glb_live;  // same latency as the channel readout
        end
    end

    a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(chan_wr_en));

    // an accepted write never names a channel past the enable vector
    a_en_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        chan_hit |-> (chan < chan_idx_t'(NUM_CHANS)));

endmodule

`default_nettype wire

// File: verilog/opl_param_pkg.sv
//--------------------
// decoded settings, field order is fixed for the engine side
//--------------------
`default_nettype none

package opl_param_pkg;
    import opl_reg_pkg::*;

    // one write on its way from the decoder to a channel block
    typedef struct packed {
        field_kind_e kind;
        logic        op_sel;   // 0 op1, 1 op2
        reg_byte_t   data;
    } reg_write_t;

    typedef struct packed {
        logic      am;         // tremolo
        logic      vib;
        logic      egt;        // sustained envelope
        logic      ksr;
        mult_t     mult;
        ksl_t      ksl;
        tl_t       tl;
        env_rate_t ar;
        env_rate_t dr;
        env_rate_t sl;
        env_rate_t rr;
        ws_t       ws;
    } op_param_t;

    typedef struct packed {
        op_param_t op1;
        op_param_t op2;
        fnum_t     fnum;
        block_t    block;
        logic      kon;
        logic      cha;        // output enables
        logic      chb;
        logic      chc;
        logic      chd;
        fb_t       fb;
        logic      cnt;        // connection, fm or additive
    } chan_param_t;

    typedef struct packed {
        logic [7:0]                timer1;
        logic [7:0]                timer2;
        logic                      irq_rst;
        logic                      mt1;
        logic                      mt2;
        logic                      st1;
        logic                      st2;
        logic [CONN_SEL_WIDTH-1:0] connection_sel;
        logic                      is_new;
        logic                      nts;
        logic                      dam;
        logic                      dvb;
        logic                      ryt;  // rhythm bits stored only
        logic                      bd;
        logic                      sd;
        logic                      tom;
        logic                      tc;
        logic                      hh;
    } global_param_t;

endpackage

`default_nettype wire

// File: verilog/opl_reg_pkg.sv
//--------------------
// register map of one bank, bank 2 sits BANK_STRIDE above bank 1
// group bases are byte offsets within a bank
//--------------------
`default_nettype none

package opl_reg_pkg;

    // host side
    typedef logic [8:0] reg_addr_t;   // bit 8 selects bank 2
    typedef logic [7:0] reg_byte_t;
    typedef logic [4:0] chan_idx_t;   // 0..17

    // field widths
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;
    typedef logic [3:0] mult_t;
    typedef logic [3:0] env_rate_t;   // ar, dr, sl, rr
    typedef logic [5:0] tl_t;
    typedef logic [1:0] ksl_t;
    typedef logic [2:0] ws_t;
    typedef logic [2:0] fb_t;

    localparam int BANK_STRIDE    = 256;
    localparam int CHANS_PER_BANK = 9;
    localparam int CONN_SEL_WIDTH = 6;

    // operator groups span 32 offsets, channel groups 16
    localparam logic [7:0] OP_GROUP_MASK = 8'hE0;
    localparam logic [7:0] CH_GROUP_MASK = 8'hF0;

    localparam logic [7:0] OP_FLAGS_BASE        = 8'h20;
    localparam logic [7:0] OP_LEVEL_BASE        = 8'h40;
    localparam logic [7:0] OP_ATTACK_DECAY_BASE = 8'h60;
    localparam logic [7:0] OP_SUST_REL_BASE     = 8'h80;
    localparam logic [7:0] OP_WAVE_BASE         = 8'hE0;
    localparam logic [7:0] CH_FNUM_LO_BASE      = 8'hA0;
    localparam logic [7:0] CH_KEY_BLOCK_BASE    = 8'hB0;
    localparam logic [7:0] CH_FEEDBACK_BASE     = 8'hC0;

    // encoded as the group base so a masked address casts straight in
    typedef enum logic [7:0] {
        op_flags           = OP_FLAGS_BASE,
        op_level           = OP_LEVEL_BASE,
        op_attack_decay    = OP_ATTACK_DECAY_BASE,
        op_sustain_release = OP_SUST_REL_BASE,
        op_wave            = OP_WAVE_BASE,
        ch_fnum_lo         = CH_FNUM_LO_BASE,
        ch_key_block       = CH_KEY_BLOCK_BASE,
        ch_feedback        = CH_FEEDBACK_BASE
    } field_kind_e;

    // chip-wide registers, full 9-bit addresses
    localparam reg_addr_t TIMER1_ADDR   = 9'h002;
    localparam reg_addr_t TIMER2_ADDR   = 9'h003;
    localparam reg_addr_t TIMER_CTRL    = 9'h004;
    localparam reg_addr_t NTS_ADDR      = 9'h008;
    localparam reg_addr_t RHYTHM_ADDR   = 9'h0BD;
    localparam reg_addr_t CONN_SEL_ADDR = reg_addr_t'(BANK_STRIDE + 4);
    localparam reg_addr_t NEW_ADDR      = reg_addr_t'(BANK_STRIDE + 5);

endpackage

`default_nettype wire
